// File: filelist.f
+incdir+verilog
+incdir+dv
verilog/pmp_pkg.sv
verilog/pmp_region_match.sv
verilog/pmp_access_check.sv
verilog/pmp_csr_regs.sv
verilog/pmp_top.sv
dv/pmp_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= pmp_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation did not pass, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/pmp_tb_model.svh
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

// Shadow copy of the CSR state
pmp_cfg_t         shadow_cfg [N];
logic [`XLEN-1:0] shadow_addr [N];
logic             shadow_rlb;
logic             shadow_mml;

function automatic void model_reset();
  for (int i = 0; i < N; i++) begin
    shadow_cfg[i]  = '0;
    shadow_addr[i] = '0;
  end
  shadow_rlb = 1'b0;
  shadow_mml = 1'b0;
endfunction

function automatic logic is_addr_csr(logic [11:0] num);
  logic [11:0] off;
  off = num - `CSR_PMPADDR0;
  return off < 12'(N);
endfunction

function automatic logic model_slverr(logic [11:0] num);
  return !((num == `CSR_PMPCFG0) || is_addr_csr(num) || (num == `CSR_MSECCFG));
endfunction

// Legal value of one cfg byte after a write
function automatic pmp_cfg_t legal_cfg(pmp_cfg_t old_cfg, pmp_cfg_t wr);
  pmp_cfg_t res;
  logic     frozen;
  frozen = (old_cfg.lock && !shadow_rlb) || (shadow_mml && !shadow_rlb && wr.lock && wr.exec);
  res = wr;
  if (wr.write && !wr.read && !shadow_mml) begin
    {res.exec, res.write, res.read} = {old_cfg.exec, old_cfg.write, old_cfg.read};
  end
  if (G > 0 && wr.mode == NA4) res.mode = old_cfg.mode;
  if (frozen) res = old_cfg;
  res.zero0 = 2'b00;
  return res;
endfunction

function automatic logic [`XLEN-1:0] addr_view_of(int i);
  logic [`XLEN-1:0] v;
  v = shadow_addr[i];
  if (shadow_cfg[i].mode == NAPOT) begin
    for (int b = 0; b < G - 1; b++) v[b] = 1'b1;
  end else begin
    for (int b = 0; b < G; b++) v[b] = 1'b0;
  end
  return v;
endfunction

function automatic logic addr_write_blocked(int i);
  if (shadow_rlb) return 1'b0;
  if (shadow_cfg[i].lock) return 1'b1;
  return (i < N - 1) && shadow_cfg[i+1].lock && (shadow_cfg[i+1].mode == TOR);
endfunction

function automatic void model_write(logic [11:0] num, logic [`XLEN-1:0] wd);
  if (num == `CSR_PMPCFG0) begin
    for (int i = 0; i < N; i++) shadow_cfg[i] = legal_cfg(shadow_cfg[i], pmp_cfg_t'(wd[8*i +: 8]));
  end else if (is_addr_csr(num)) begin
    if (!addr_write_blocked(int'(num - `CSR_PMPADDR0))) begin
      shadow_addr[int'(num - `CSR_PMPADDR0)] = wd;
    end
  end else if (num == `CSR_MSECCFG) begin
    shadow_rlb = wd[2];
    shadow_mml = shadow_mml | wd[0]; // Only reset clears MML
  end
endfunction

function automatic logic [`XLEN-1:0] model_read(logic [11:0] num);
  logic [`XLEN-1:0] v;
  v = '0;
  if (num == `CSR_PMPCFG0) begin
    for (int i = 0; i < N; i++) v[8*i +: 8] = shadow_cfg[i];
  end else if (is_addr_csr(num)) begin
    v = addr_view_of(int'(num - `CSR_PMPADDR0));
  end else if (num == `CSR_MSECCFG) begin
    v[2] = shadow_rlb;
    v[0] = shadow_mml;
  end
  return v;
endfunction

function automatic logic region_matches(int i, logic [`XLEN-1:0] byte_addr);
  logic [`XLEN-1:0] word;
  logic [`XLEN-1:0] top;
  logic [`XLEN-1:0] base;
  int               ones;
  word = byte_addr >> 2;
  top  = addr_view_of(i);
  base = (i == 0) ? '0 : addr_view_of(i - 1);
  case (shadow_cfg[i].mode)
    TOR: return (word >= base) && (word < top);
    NA4: return word == top;
    NAPOT: begin
      ones = 0;
      while (ones < `XLEN && top[ones]) ones++; // Block of 2^(ones+1) words
      return ({32'b0, word} >> (ones + 1)) == ({32'b0, top} >> (ones + 1));
    end
    default: return 1'b0;
  endcase
endfunction

function automatic pmp_rsp_t model_decide(logic [`XLEN-1:0] byte_addr, pmp_acc_e acc,
                                          pmp_priv_e priv);
  pmp_rsp_t r;
  logic     perm;
  r         = '0;
  r.valid   = 1'b1;
  r.allowed = (priv == PRIV_M); // No match
  for (int i = 0; i < N; i++) begin
    if (!r.matched && region_matches(i, byte_addr)) begin
      r.matched = 1'b1;
      r.region  = RW'(i);
      case (acc)
        ACC_READ:  perm = shadow_cfg[i].read;
        ACC_WRITE: perm = shadow_cfg[i].write;
        default:   perm = shadow_cfg[i].exec;
      endcase
      r.allowed = perm || ((priv == PRIV_M) && !shadow_cfg[i].lock);
    end
  end
  return r;
endfunction

`endif

// File: dv/pmp_tb.sv
`include "pmp_macros.svh"

module pmp_tb
  import pmp_pkg::*;
;

  localparam int N  = `PMP_NUM_REGIONS;
  localparam int G  = `PMP_GRANULARITY;
  localparam int RW = $clog2(N);
  localparam int CLK_PERIOD = 40;
  localparam int T1_ITERS = 24;
  localparam int T2_ITERS = 16;
  localparam int T5_ROUNDS = 4;
  localparam int BURST = 24;
  // APB transfers plus burst requests over all six tests
  localparam int NUM_XFERS = T1_ITERS * 3 + T2_ITERS * (1 + 2 * N) + N * 8 + 3 + (N - 1) * 4
                             + T5_ROUNDS * (N + 3 + BURST) + 24;
  localparam int WATCHDOG_TIME = NUM_XFERS * 4 * CLK_PERIOD + 200 * CLK_PERIOD;

  logic        clk;
  logic        arst_n;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  pmp_req_t    pmp_req;
  pmp_rsp_t    pmp_rsp;
  logic [15:0] lfsr = 16'd5343;
  int          checks = 0;
  int          errors = 0;

  `include "pmp_tb_model.svh"

  pmp_top DUT (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .pmp_req_i (pmp_req),
    .pmp_rsp_o (pmp_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_rdata(input logic [11:0] num, input logic [`XLEN-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail prdata (CSR 0x%h): got 0x%h, expected 0x%h", num, got, exp);
    end
  endtask

  task automatic check_slverr(input logic [11:0] num, input logic got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail pslverr (CSR 0x%h): got 0x%h, expected 0x%h", num, got, exp);
    end
  endtask

  task automatic check_rsp(input pmp_rsp_t got, exp);
    checks++;
    if (got.valid !== 1'b1) begin
      errors++;
      $display("Error: checker response valid missing one cycle after the request");
    end else if (got !== exp) begin
      errors++;
      $display("Fail pmp_rsp_o: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    model_reset();
  endtask

  // One setup cycle and one access cycle with no wait states
  task automatic apb_xfer(input logic wr, input logic [11:0] num, input logic [`XLEN-1:0] wd,
                          output logic [`XLEN-1:0] rd, output logic err);
    apb_req_t req;
    req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: {num, 2'b00}, pwdata: wd};
    @(posedge clk);
    apb_req <= req;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    if (!apb_rsp.pready) begin
      errors++;
      $display("Error: pready low in the access phase for CSR 0x%h", num);
    end
    rd = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic csr_write(input logic [11:0] num, input logic [`XLEN-1:0] wd);
    logic [`XLEN-1:0] rd;
    logic             err;
    apb_xfer(1'b1, num, wd, rd, err);
    check_slverr(num, err, model_slverr(num));
    model_write(num, wd);
  endtask

  task automatic csr_read_check(input logic [11:0] num);
    logic [`XLEN-1:0] rd;
    logic             err;
    apb_xfer(1'b0, num, '0, rd, err);
    check_slverr(num, err, model_slverr(num));
    if (!model_slverr(num)) check_rdata(num, rd, model_read(num));
  endtask

  task automatic report_test(input string name, input int start);
    $display("Test %s finished, %0d errors", name, errors - start);
  endtask

  task automatic cfg_legalization();
    logic [31:0] r;
    int          start;
    start = errors;
    apply_reset();
    for (int k = 0; k < T1_ITERS; k++) begin
      r = rand_bits(2);
      csr_write(`CSR_MSECCFG, {29'b0, r[1], 1'b0, r[0] & (k >= T1_ITERS / 2)}); // MML late
      csr_write(`CSR_PMPCFG0, rand_bits(32));
      csr_read_check(`CSR_PMPCFG0);
    end
    report_test("cfg legalization", start);
  endtask

  task automatic granularity_readback();
    int start;
    start = errors;
    apply_reset();
    for (int k = 0; k < T2_ITERS; k++) begin
      csr_write(`CSR_PMPCFG0, rand_bits(32) & 32'h7F7F7F7F); // Lock bits kept clear
      for (int i = 0; i < N; i++) csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      for (int i = 0; i < N; i++) csr_read_check(`CSR_PMPADDR0 + 12'(i));
    end
    report_test("granularity read-back", start);
  endtask

  task automatic entry_locking();
    logic [`XLEN-1:0] rd;
    logic             err;
    int               start;
    start = errors;
    apply_reset();
    for (int i = 0; i < N; i++) begin
      csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      csr_write(`CSR_PMPCFG0, 32'h99 << (8 * i)); // Locked NAPOT with read only
      csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      csr_read_check(`CSR_PMPADDR0 + 12'(i));
      csr_write(`CSR_MSECCFG, 32'h4);
      csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      csr_read_check(`CSR_PMPADDR0 + 12'(i));
      csr_write(`CSR_MSECCFG, 32'h0);
    end
    csr_write(`CSR_MSECCFG, 32'h1);
    csr_write(`CSR_MSECCFG, 32'h0);
    apb_xfer(1'b0, `CSR_MSECCFG, '0, rd, err);
    check_rdata(`CSR_MSECCFG, rd, 32'h1); // MML survives a write of zero
    report_test("locking", start);
  endtask

  task automatic locked_tor_base();
    int start;
    start = errors;
    for (int i = 0; i < N - 1; i++) begin
      apply_reset();
      csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      csr_write(`CSR_PMPCFG0, 32'h89 << (8 * (i + 1))); // Entry above is locked TOR
      csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(32));
      csr_read_check(`CSR_PMPADDR0 + 12'(i));
    end
    report_test("locked TOR", start);
  endtask

  // Back-to-back requests with each answer one cycle later
  task automatic request_burst();
    pmp_req_t    req;
    pmp_rsp_t    expq[$];
    logic [31:0] r;
    for (int k = 0; k <= BURST; k++) begin
      @(posedge clk);
      if (k < BURST) begin
        r         = rand_bits(13);
        req.valid = 1'b1;
        req.addr  = {22'b0, r[9:0]};
        req.acc   = (r[11:10] == 2'd3) ? ACC_READ : pmp_acc_e'(r[11:10]);
        req.priv  = r[12] ? PRIV_M : PRIV_U;
        pmp_req <= req;
        expq.push_back(model_decide(req.addr, req.acc, req.priv));
      end else begin
        pmp_req <= '0;
      end
      @(negedge clk);
      if (k > 0) check_rsp(pmp_rsp, expq.pop_front());
    end
  endtask

  task automatic access_decisions();
    int start;
    start = errors;
    apply_reset();
    for (int k = 0; k < T5_ROUNDS; k++) begin
      csr_write(`CSR_MSECCFG, 32'h4); // RLB opens locked entries again
      for (int i = 0; i < N; i++) csr_write(`CSR_PMPADDR0 + 12'(i), rand_bits(8));
      csr_write(`CSR_PMPCFG0, rand_bits(32));
      csr_write(`CSR_MSECCFG, 32'h0);
      request_burst();
    end
    report_test("access decisions", start);
  endtask

  task automatic unmapped_csrs();
    logic [11:0]      bad [8] = '{12'h3A1, 12'h3A2, 12'h3A3, 12'h3AF,
                                  12'h3B4, 12'h746, 12'h748, 12'h000};
    logic [`XLEN-1:0] rd;
    logic             err;
    logic [31:0]      r;
    int               start;
    start = errors;
    apply_reset();
    for (int k = 0; k < 8; k++) begin
      apb_xfer(k[0], bad[k], rand_bits(32), rd, err);
      check_slverr(bad[k], err, 1'b1);
    end
    csr_read_check(`CSR_PMPCFG0);
    for (int i = 0; i < N; i++) csr_read_check(`CSR_PMPADDR0 + 12'(i));
    csr_read_check(`CSR_MSECCFG);
    csr_write(`CSR_PMPCFG0, 32'h80);
    csr_write(`CSR_PMPADDR0, rand_bits(32)); // Dropped by the lock without an error
    for (int k = 0; k < 8; k++) begin
      r = rand_bits(12);
      csr_read_check(r[11:0]);
    end
    report_test("unmapped CSRs", start);
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: run did not finish within %0d time units", WATCHDOG_TIME);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    arst_n  = 1'b0;
    apb_req = '0;
    pmp_req = '0;
    model_reset();
    cfg_legalization();
    granularity_readback();
    entry_locking();
    locked_tor_base();
    access_decisions();
    unmapped_csrs();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/pmp_top.sv
module pmp_top
  import pmp_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  input  pmp_req_t pmp_req_i,
  output pmp_rsp_t pmp_rsp_o
);

  pmp_csr_t csr; // Register view feeding the checker

  pmp_csr_regs u_csr_regs (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .apb_req_i (apb_req_i),
    .apb_rsp_o (apb_rsp_o),
    .csr_o     (csr)
  );

  pmp_access_check u_access_check (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .csr_i    (csr),
    .req_i    (pmp_req_i),
    .rsp_o    (pmp_rsp_o)
  );

endmodule

// File: verilog/pmp_csr_regs.sv
`include "pmp_macros.svh"

module pmp_csr_regs
  import pmp_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  output apb_rsp_t apb_rsp_o,
  output pmp_csr_t csr_o
);

  localparam int N = `PMP_NUM_REGIONS;
  localparam int G = `PMP_GRANULARITY;
  localparam int IDX_W = $clog2(N);
  localparam logic [`XLEN-1:0] ZERO_MASK = (`XLEN'(1) << G) - `XLEN'(1); // Low G bits
  localparam logic [`XLEN-1:0] ONES_MASK = ZERO_MASK >> 1;               // Low G-1 bits

  pmp_cfg_t [N-1:0]             cfg_q, cfg_d;
  logic [N-1:0][`XLEN-1:0]      addr_q, addr_d;
  logic [N-1:0][`XLEN-1:0]      addr_view;
  logic [N-1:0]                 addr_lock;
  mseccfg_t                     mseccfg_q, mseccfg_d;
  logic [`CSR_NUM_W-1:0]        csr_num;
  logic [`CSR_NUM_W-1:0]        addr_off;
  logic [IDX_W-1:0]             addr_idx;
  logic                         access, wr_en;
  logic                         sel_cfg, sel_addr, sel_mseccfg;
  logic [`XLEN-1:0]             rdata;

  // WARL rules for one pmpcfg byte
  function automatic pmp_cfg_t legalize_cfg(pmp_cfg_t old_cfg, pmp_cfg_t new_cfg,
                                            mseccfg_t sec);
    pmp_cfg_t cfg;
    cfg = new_cfg;
    if (new_cfg.write && !new_cfg.read && !sec.mml) begin // RW=01 reserved
      cfg.exec  = old_cfg.exec;
      cfg.write = old_cfg.write;
      cfg.read  = old_cfg.read;
    end
    if ((G >= 1) && (new_cfg.mode == NA4)) cfg.mode = old_cfg.mode; // No NA4 above G=0
    if (old_cfg.lock && !sec.rlb) cfg = old_cfg;
    if (sec.mml && !sec.rlb && new_cfg.lock && new_cfg.exec) cfg = old_cfg;
    cfg.zero0 = 2'b00;
    return cfg;
  endfunction

  assign access   = apb_req_i.psel && apb_req_i.penable;
  assign wr_en    = access && apb_req_i.pwrite;
  assign csr_num  = apb_req_i.paddr[`CSR_NUM_W+1:2];
  assign addr_off = csr_num - `CSR_PMPADDR0; // Wraps high below pmpaddr0
  assign addr_idx = addr_off[IDX_W-1:0];

  assign sel_cfg     = (csr_num == `CSR_PMPCFG0);
  assign sel_addr    = (addr_off < `CSR_NUM_W'(N));
  assign sel_mseccfg = (csr_num == `CSR_MSECCFG);

  for (genvar i = 0; i < N; i++) begin : gen_entry
    // A locked TOR entry also guards the base address below it
    if (i < N - 1) begin : gen_tor_guard
      assign addr_lock[i] = !mseccfg_q.rlb &&
                            (cfg_q[i].lock || (cfg_q[i+1].lock && (cfg_q[i+1].mode == TOR)));
    end else begin : gen_top_entry
      assign addr_lock[i] = !mseccfg_q.rlb && cfg_q[i].lock;
    end
    assign addr_view[i] = (cfg_q[i].mode == NAPOT) ? (addr_q[i] | ONES_MASK)
                                                   : (addr_q[i] & ~ZERO_MASK);
  end

  always_comb begin
    cfg_d     = cfg_q;
    addr_d    = addr_q;
    mseccfg_d = mseccfg_q;
    if (wr_en && sel_cfg) begin
      for (int i = 0; i < N; i++) begin
        cfg_d[i] = legalize_cfg(cfg_q[i], pmp_cfg_t'(apb_req_i.pwdata[8*i +: 8]), mseccfg_q);
      end
    end
    if (wr_en && sel_addr && !addr_lock[addr_idx]) addr_d[addr_idx] = apb_req_i.pwdata;
    if (wr_en && sel_mseccfg) begin
      mseccfg_d.rlb = apb_req_i.pwdata[2];
      mseccfg_d.mml = mseccfg_q.mml | apb_req_i.pwdata[0]; // Sticky until reset
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      mseccfg_q <= '0;
    end else begin
      cfg_q     <= cfg_d;
      addr_q    <= addr_d;
      mseccfg_q <= mseccfg_d;
    end
  end

  // Read-back view
  always_comb begin
    rdata = '0;
    if (sel_cfg) begin
      for (int i = 0; i < N; i++) rdata[8*i +: 8] = cfg_q[i];
    end else if (sel_addr) begin
      rdata = addr_view[addr_idx];
    end else if (sel_mseccfg) begin
      rdata[2] = mseccfg_q.rlb;
      rdata[0] = mseccfg_q.mml;
    end
  end

  assign apb_rsp_o.pready  = access; // No wait states
  assign apb_rsp_o.pslverr = access && !(sel_cfg || sel_addr || sel_mseccfg);
  assign apb_rsp_o.prdata  = rdata;

  assign csr_o.cfg     = cfg_q;
  assign csr_o.addr    = addr_view;
  assign csr_o.mseccfg = mseccfg_q;

endmodule

// File: verilog/pmp_access_check.sv
`include "pmp_macros.svh"

module pmp_access_check
  import pmp_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  pmp_csr_t csr_i,
  input  pmp_req_t req_i,
  output pmp_rsp_t rsp_o
);

  localparam int N = `PMP_NUM_REGIONS;
  localparam int REGION_W = $clog2(N);

  logic [N-1:0]             match;
  logic [N-1:0][`XLEN-1:0]  prev_addr;
  logic                     hit;
  logic [REGION_W-1:0]      hit_idx;
  pmp_cfg_t                 hit_cfg;
  logic                     perm;
  logic                     allowed;
  pmp_rsp_t                 rsp_q;

  for (genvar i = 0; i < N; i++) begin : gen_region
    if (i == 0) begin : gen_base
      assign prev_addr[i] = '0;
    end else begin : gen_chain
      assign prev_addr[i] = csr_i.addr[i-1];
    end

    pmp_region_match u_match (
      .cfg_i       (csr_i.cfg[i]),
      .addr_i      (csr_i.addr[i]),
      .prev_addr_i (prev_addr[i]),
      .req_addr_i  (req_i.addr),
      .match_o     (match[i])
    );
  end

  // Lowest-numbered match wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = REGION_W'(i);
      end
    end
  end

  assign hit_cfg = csr_i.cfg[hit_idx];

  always_comb begin
    case (req_i.acc)
      ACC_READ:  perm = hit_cfg.read;
      ACC_WRITE: perm = hit_cfg.write;
      ACC_EXEC:  perm = hit_cfg.exec;
      default:   perm = 1'b0;
    endcase
  end

  // M-mode bypasses unlocked entries, default is M-only
  assign allowed = hit ? (((req_i.priv == PRIV_M) && !hit_cfg.lock) || perm)
                       : (req_i.priv == PRIV_M);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid   <= req_i.valid;
      rsp_q.allowed <= req_i.valid && allowed;
      rsp_q.matched <= req_i.valid && hit;
      rsp_q.region  <= hit_idx;
    end
  end

  assign rsp_o = rsp_q;

endmodule

// File: verilog/pmp_region_match.sv
`include "pmp_macros.svh"

module pmp_region_match
  import pmp_pkg::*;
(
  input  pmp_cfg_t         cfg_i,
  input  logic [`XLEN-1:0] addr_i,      // pmpaddr, address bits 33:2
  input  logic [`XLEN-1:0] prev_addr_i, // TOR base
  input  logic [`XLEN-1:0] req_addr_i,
  output logic             match_o
);

  logic [`XLEN-1:0] req_word;
  logic [`XLEN-1:0] napot_care;

  // Word address in pmpaddr format, upper two bits always zero
  assign req_word = {2'b00, req_addr_i[`XLEN-1:2]};

  // Trailing ones plus the next bit are don't-care within the block
  assign napot_care = ~(addr_i ^ (addr_i + `XLEN'(1)));

  always_comb begin
    unique case (cfg_i.mode)
      TOR:     match_o = (req_word >= prev_addr_i) && (req_word < addr_i);
      NA4:     match_o = (req_word == addr_i);
      NAPOT:   match_o = ((req_word & napot_care) == (addr_i & napot_care));
      default: match_o = 1'b0; // OFF
    endcase
  end

endmodule

// File: verilog/pmp_pkg.sv
`include "pmp_macros.svh"

package pmp_pkg;

  // Address matching mode, A field of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  typedef struct packed {
    logic      lock;
    logic [1:0] zero0; // Reserved, read as zero
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } pmp_acc_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } pmp_priv_e;

  // Lower mseccfg bits kept by this unit
  typedef struct packed {
    logic rlb;
    logic mml;
  } mseccfg_t;

  // CSR state as seen by the checker
  typedef struct packed {
    pmp_cfg_t [`PMP_NUM_REGIONS-1:0]            cfg;
    logic [`PMP_NUM_REGIONS-1:0][`XLEN-1:0]     addr;
    mseccfg_t                                   mseccfg;
  } pmp_csr_t;

  typedef struct packed {
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`XLEN-1:0]       pwdata;
  } apb_req_t;

  typedef struct packed {
    logic             pready;
    logic             pslverr;
    logic [`XLEN-1:0] prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;  // Byte address
    pmp_acc_e         acc;
    pmp_priv_e        priv;
  } pmp_req_t;

  typedef struct packed {
    logic                                 valid;
    logic                                 allowed;
    logic                                 matched;
    logic [$clog2(`PMP_NUM_REGIONS)-1:0]  region;
  } pmp_rsp_t;

endpackage

// File: verilog/pmp_macros.svh
`ifndef PMP_MACROS_SVH
`define PMP_MACROS_SVH

// Region count and granularity G (region size 2^(G+2) bytes)
`define PMP_NUM_REGIONS 4
`define PMP_GRANULARITY 2

`define XLEN       32
`define APB_ADDR_W 14 // Byte address, CSR number in bits 13:2
`define CSR_NUM_W  12

// CSR numbers
`define CSR_PMPCFG0  12'h3A0
`define CSR_PMPADDR0 12'h3B0
`define CSR_MSECCFG  12'h747

`endif
